// ==== Bender.yml ====
package:
  name: matr_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/matr_pkg.sv
      - hdl/inst_rom.sv
      - hdl/inst_fetch.sv
      - hdl/matr_unit.sv
      - hdl/data_ram.sv
      - hdl/axil_regs.sv
      - hdl/matr_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/matr_top_tb.sv

// ==== compile.f ====
+incdir+include
hdl/matr_pkg.sv
hdl/inst_rom.sv
hdl/inst_fetch.sv
hdl/matr_unit.sv
hdl/data_ram.sv
hdl/axil_regs.sv
hdl/matr_top.sv
testbench/matr_top_tb.sv

// ==== hdl/axil_regs.sv ====
`timescale 1ns/1ps
`include "matr_params.svh"

module axil_regs
(
   input  logic                clk_50,
   input  logic                arst_n,
   input  logic [`AXI_AW-1:0]  awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  matr_pkg::word_t     wdata,
   input  logic [3:0]          wstrb,
   input  logic                wvalid,
   output logic                wready,
   output logic [1:0]          bresp,
   output logic                bvalid,
   input  logic                bready,
   input  logic [`AXI_AW-1:0]  araddr,
   input  logic                arvalid,
   output logic                arready,
   output matr_pkg::word_t     rdata,
   output logic [1:0]          rresp,
   output logic                rvalid,
   input  logic                rready,
   output matr_pkg::ram_addr_t a_addr,
   output logic                a_we,
   output matr_pkg::word_t     a_wdata,
   input  matr_pkg::word_t     a_rdata,
   input  logic                matr_busy,
   input  matr_pkg::mcount_t   matr_count,
   input  logic                halted,
   output logic                run,
   output matr_pkg::ram_addr_t base_a,
   output matr_pkg::ram_addr_t base_b,
   output matr_pkg::ram_addr_t base_c
);
   import matr_pkg::*;

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   axil_state_t state;
   logic        aw_ram;                                    // write hits the ram window
   logic        ar_ram;
   logic        wr_go;                                     // write handshake this cycle
   logic        rd_go;
   logic        reg_hit;                                   // araddr names a register
   word_t       reg_rd;

   assign aw_ram = awaddr[`AXI_AW-1:8] == '0;              // 0x000 to 0x0ff
   assign ar_ram = araddr[`AXI_AW-1:8] == '0;

   // aw and w together, writes first, ram held off while the coprocessor owns it
   assign wr_go   = (state == a_idle) && awvalid && wvalid && !(aw_ram && matr_busy);
   assign rd_go   = (state == a_idle) && arvalid && !wr_go && !(ar_ram && matr_busy);
   assign awready = wr_go;
   assign wready  = wr_go;
   assign arready = rd_go;

   assign a_addr  = wr_go ? awaddr[`RAM_AW+1:2] : araddr[`RAM_AW+1:2];
   assign a_we    = wr_go && aw_ram;
   assign a_wdata = wdata;

   always_comb
   begin
      reg_hit = 1'b1;
      case (araddr)
         `REG_BASE_A : reg_rd = word_t'(base_a);
         `REG_BASE_B : reg_rd = word_t'(base_b);
         `REG_BASE_C : reg_rd = word_t'(base_c);
         `REG_CTRL   : reg_rd = word_t'(run);
         `REG_STATUS : reg_rd = {16'h0, matr_count, 6'h0, halted, matr_busy};
         default     :
         begin
            reg_rd  = '0;                                  // unmapped reads as zero
            reg_hit = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk_50 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state  <= a_idle;
         bvalid <= 1'b0;
         bresp  <= resp_okay;
         rvalid <= 1'b0;
         rresp  <= resp_okay;
         rdata  <= '0;
         run    <= 1'b0;
         base_a <= '0;
         base_b <= '0;
         base_c <= '0;
      end
      else
      begin
         case (state)
            a_idle :
               if (wr_go)
               begin
                  bvalid <= 1'b1;
                  bresp  <= resp_okay;
                  state  <= a_resp;
                  case (awaddr)
                     `REG_BASE_A : base_a <= wdata[`RAM_AW-1:0];
                     `REG_BASE_B : base_b <= wdata[`RAM_AW-1:0];
                     `REG_BASE_C : base_c <= wdata[`RAM_AW-1:0];
                     `REG_CTRL   : run    <= wdata[0];
                     `REG_STATUS : ;                       // read only, write dropped
                     default     :
                        if (!aw_ram)
                           bresp <= resp_slverr;
                  endcase
               end
               else if (rd_go)
               begin
                  if (ar_ram)
                     state <= a_ram_wait;                  // ram sampled a_addr this edge
                  else
                  begin
                     rvalid <= 1'b1;
                     rdata  <= reg_rd;
                     rresp  <= reg_hit ? resp_okay : resp_slverr;
                     state  <= a_resp;
                  end
               end
            a_ram_wait :
            begin
               rvalid <= 1'b1;
               rdata  <= a_rdata;
               rresp  <= resp_okay;
               state  <= a_resp;
            end
            default :
               if ((bvalid && bready) || (rvalid && rready))
               begin
                  bvalid <= 1'b0;
                  rvalid <= 1'b0;
                  state  <= a_idle;
               end
         endcase
      end
   end

   a_bvalid : assert property (@(posedge clk_50) disable iff (!arst_n)
      $rose(bvalid) |-> $past(wr_go))
      else $error("write response without a write handshake");

   a_wstrb : assert property (@(posedge clk_50) disable iff (!arst_n)
      wr_go |-> wstrb == 4'hF)
      else $error("partial write strobe %b", wstrb);

endmodule

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps
`include "matr_params.svh"

module data_ram
(
   input  logic                clk_50,
   input  matr_pkg::ram_addr_t a_addr,
   input  logic                a_we,
   input  matr_pkg::word_t     a_wdata,
   output matr_pkg::word_t     a_rdata,
   input  matr_pkg::ram_addr_t b_addr,
   input  logic                b_we,
   input  matr_pkg::word_t     b_wdata,
   output matr_pkg::word_t     b_rdata
);
   import matr_pkg::*;

   word_t mem [`RAM_WORDS];

   always_ff @(posedge clk_50)
   begin
      if (a_we)
         mem[a_addr] <= a_wdata;                           // host port
      if (b_we)
         mem[b_addr] <= b_wdata;                           // later write, b wins a collision
      a_rdata <= mem[a_addr];                              // old data on same-port write
      b_rdata <= mem[b_addr];
   end

endmodule

// ==== hdl/inst_fetch.sv ====
`timescale 1ns/1ps
`include "matr_params.svh"

module inst_fetch
(
   input  logic            clk_50,
   input  logic            arst_n,
   input  logic            run,
   output matr_pkg::pc_t   rom_addr,
   input  matr_pkg::inst_t rom_data,
   output matr_pkg::inst_t inst,
   output matr_pkg::pc_t   inst_pc,
   output logic            inst_valid,
   input  logic            inst_ready,
   output logic            matr_start,
   input  logic            matr_busy,
   output logic            halted
);
   import matr_pkg::*;

   fetch_state_t state;
   pc_t          pc;
   logic         is_matr;                                  // rom word is the matrix instruction

   assign rom_addr   = pc;                                 // rom samples pc on every edge
   assign is_matr    = rom_data[6:0] == `MATR_OPCODE;
   assign matr_start = (state == f_read) && is_matr;      // read lasts one cycle, so a pulse

   always_ff @(posedge clk_50 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state      <= f_idle;
         pc         <= '0;
         inst_valid <= 1'b0;
         halted     <= 1'b0;
      end
      else
      begin
         case (state)
            f_idle :
               if (run)
                  state <= f_read;                         // word 0 arrives next cycle
            f_read :
               if (rom_data == '0)
               begin
                  state  <= f_halted;                      // never offered
                  halted <= 1'b1;
               end
               else
               begin
                  pc <= pc + 4;                            // rom fetches next word meanwhile
                  if (is_matr)
                     state <= f_wait_matr;
                  else
                  begin
                     inst_valid <= 1'b1;
                     state      <= f_hold;
                  end
               end
            f_hold :
               if (inst_ready)
               begin
                  inst_valid <= 1'b0;
                  state      <= f_read;
               end
            f_wait_matr :
               if (!matr_busy)                             // busy is up the cycle after start
               begin
                  inst_valid <= 1'b1;
                  state      <= f_hold;
               end
            default :
               state <= f_halted;                          // stays here until reset
         endcase
      end
   end

   // holding register
   always_ff @(posedge clk_50)
   begin
      if (state == f_read)
      begin
         inst    <= rom_data;
         inst_pc <= pc;                                    // pc still names the word on rom_data
      end
   end

   a_stall : assert property (@(posedge clk_50) disable iff (!arst_n)
      inst_valid && !inst_ready |=> inst_valid && $stable(inst) && $stable(inst_pc))
      else $error("instruction changed while stalled");

   a_start : assert property (@(posedge clk_50) disable iff (!arst_n)
      matr_start |-> !matr_busy)
      else $error("matrix start while coprocessor busy");

endmodule

// ==== hdl/inst_rom.sv ====
`timescale 1ns/1ps
`include "matr_params.svh"

module inst_rom
(
   input  logic            clk_50,
   input  matr_pkg::pc_t   rom_addr,
   output matr_pkg::inst_t rom_data
);

   always_ff @(posedge clk_50)
   begin
      case (rom_addr)
         0       : rom_data <= 32'h00000013;   // nop
         4       : rom_data <= 32'h00000013;   // nop
         8       : rom_data <= 32'h00000013;   // nop
         12      : rom_data <= 32'h00000013;   // nop
         16      : rom_data <= 32'h00000013;   // nop
         20      : rom_data <= 32'hff810113;   // addi sp, sp, -8
         24      : rom_data <= 32'h01412223;   // sw s4, 4(sp)
         28      : rom_data <= 32'h01312023;   // sw s3, 0(sp)
         32      : rom_data <= 32'h00400993;   // addi s3, zero, 4   outer index
         36      : rom_data <= 32'h00000a13;   // addi s4, zero, 0   inner index
         40      : rom_data <= 32'h00000793;   // addi a5, zero, 0   a base
         44      : rom_data <= 32'h02400813;   // addi a6, zero, 36  b base
         48      : rom_data <= 32'h04800893;   // addi a7, zero, 72  c base
         52      : rom_data <= 32'h00f8188b;   // matr a7, a6, a5 on custom-0
         56      : rom_data <= 32'h00000513;   // addi a0, zero, 0
         60      : rom_data <= 32'h02800613;   // addi a2, zero, 40  sort length in bytes
         64      : rom_data <= 32'h04800293;   // addi t0, zero, 72  sort the product
         68      : rom_data <= 32'h04c9d863;   // bge s3, a2, exit
         72      : rom_data <= 32'h00000e33;   // add t3, zero, zero
         76      : rom_data <= 32'h41360e33;   // sub t3, a2, s3
         80      : rom_data <= 32'h000a0f13;   // addi t5, s4, 0
         84      : rom_data <= 32'h03cf5863;   // bge t5, t3, exit1
         88      : rom_data <= 32'h0002a503;   // lw a0, 0(t0)
         92      : rom_data <= 32'h0042a583;   // lw a1, 4(t0)
         96      : rom_data <= 32'h00428293;   // addi t0, t0, 4
         100     : rom_data <= 32'h02a5d463;   // bge a1, a0, exit2  already ordered
         104     : rom_data <= 32'h00050f93;   // addi t6, a0, 0     swap
         108     : rom_data <= 32'h00058513;   // addi a0, a1, 0
         112     : rom_data <= 32'h000f8593;   // addi a1, t6, 0
         116     : rom_data <= 32'hfea2ae23;   // sw a0, -4(t0)
         120     : rom_data <= 32'h00b2a023;   // sw a1, 0(t0)
         124     : rom_data <= 32'h004f0f13;   // addi t5, t5, 4
         128     : rom_data <= 32'hfc000ae3;   // beq zero, zero, loop2
         132     : rom_data <= 32'h00498993;   // addi s3, s3, 4     exit1
         136     : rom_data <= 32'hfa0008e3;   // beq zero, zero, loop1
         140     : rom_data <= 32'h004f0f13;   // addi t5, t5, 4     exit2
         144     : rom_data <= 32'hfc0002e3;   // beq zero, zero, loop2
         148     : rom_data <= 32'h00013983;   // lw s3, 0(sp)       exit, restore
         152     : rom_data <= 32'h00413a03;   // lw s4, 4(sp)
         156     : rom_data <= 32'h00810113;   // addi sp, sp, 8
         160     : rom_data <= 32'h00a54533;   // xor a0, a0, a0     last word
         default : rom_data <= '0;             // zero word ends the program
      endcase
   end

   // fetch steps by four and halts long before the end of the rom
   a_rom_addr : assert property (@(posedge clk_50)
      rom_addr[1:0] == 2'b00 && rom_addr < 4 * `ROM_WORDS)
      else $error("rom address %0h unaligned or out of range", rom_addr);

endmodule

// ==== hdl/matr_pkg.sv ====
`include "matr_params.svh"

package matr_pkg;

   typedef logic [`INST_W-1:0] inst_t;
   typedef logic [`ADDR_W-1:0] pc_t;       // byte address
   typedef logic [31:0]        word_t;     // data word, treated as signed by the multiplier
   typedef logic [`RAM_AW-1:0] ram_addr_t;
   typedef logic [7:0]         mcount_t;   // retired matrix instructions

   // fetch sequencer
   typedef enum logic [2:0]
   {
      f_idle,
      f_read,                              // rom word for pc is on rom_data
      f_hold,                              // offering inst downstream
      f_wait_matr,                         // coprocessor still working
      f_halted
   } fetch_state_t;

   // matrix coprocessor
   typedef enum logic [2:0]
   {
      m_idle,
      m_read_a,
      m_read_b,
      m_accum,
      m_store,
      m_done
   } matr_state_t;

   // host bus slave
   typedef enum logic [1:0]
   {
      a_idle,
      a_ram_wait,                          // ram read in flight
      a_resp
   } axil_state_t;

endpackage

// ==== hdl/matr_top.sv ====
`timescale 1ns/1ps
`include "matr_params.svh"

module matr_top
(
   input  logic                clk_50,
   input  logic                arst_n,
   input  logic [`AXI_AW-1:0]  awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  matr_pkg::word_t     wdata,
   input  logic [3:0]          wstrb,
   input  logic                wvalid,
   output logic                wready,
   output logic [1:0]          bresp,
   output logic                bvalid,
   input  logic                bready,
   input  logic [`AXI_AW-1:0]  araddr,
   input  logic                arvalid,
   output logic                arready,
   output matr_pkg::word_t     rdata,
   output logic [1:0]          rresp,
   output logic                rvalid,
   input  logic                rready,
   output matr_pkg::inst_t     inst,
   output matr_pkg::pc_t       inst_pc,
   output logic                inst_valid,
   input  logic                inst_ready,
   output logic                halted
);
   import matr_pkg::*;

   pc_t       rom_addr;
   inst_t     rom_data;
   logic      run;
   logic      matr_start;
   logic      matr_busy;
   mcount_t   matr_count;
   ram_addr_t base_a;
   ram_addr_t base_b;
   ram_addr_t base_c;
   ram_addr_t a_addr;                                      // host side of the ram
   logic      a_we;
   word_t     a_wdata;
   word_t     a_rdata;
   ram_addr_t b_addr;                                      // coprocessor side
   logic      b_we;
   word_t     b_wdata;
   word_t     b_rdata;

   // ports and nets share names, so everything connects by name
   inst_rom   u_rom   (.*);
   inst_fetch u_fetch (.*);
   matr_unit  u_matr  (.*);
   data_ram   u_ram   (.*);
   axil_regs  u_regs  (.*);

endmodule

// ==== hdl/matr_unit.sv ====
`timescale 1ns/1ps
`include "matr_params.svh"

module matr_unit
(
   input  logic                clk_50,
   input  logic                arst_n,
   input  logic                matr_start,
   input  matr_pkg::ram_addr_t base_a,
   input  matr_pkg::ram_addr_t base_b,
   input  matr_pkg::ram_addr_t base_c,
   output matr_pkg::ram_addr_t b_addr,
   output logic                b_we,
   output matr_pkg::word_t     b_wdata,
   input  matr_pkg::word_t     b_rdata,
   output logic                matr_busy,
   output matr_pkg::mcount_t   matr_count
);
   import matr_pkg::*;

   matr_state_t state;
   logic [1:0]  i_idx;                                     // row of c
   logic [1:0]  j_idx;                                     // column of c
   logic [1:0]  k_idx;                                     // dot product term
   word_t       a_val;                                     // a[i][k] kept while b is read
   word_t       acc;

   assign matr_busy = (state != m_idle);
   assign b_we      = (state == m_store);
   assign b_wdata   = acc;

   // row-major with element at base + 3*row + col
   always_comb
   begin
      case (state)
         m_read_a : b_addr = base_a + ram_addr_t'(`MAT_N * i_idx + k_idx);
         m_read_b : b_addr = base_b + ram_addr_t'(`MAT_N * k_idx + j_idx);
         m_store  : b_addr = base_c + ram_addr_t'(`MAT_N * i_idx + j_idx);
         default  : b_addr = base_c;
      endcase
   end

   always_ff @(posedge clk_50 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state      <= m_idle;
         i_idx      <= '0;
         j_idx      <= '0;
         k_idx      <= '0;
         matr_count <= '0;
      end
      else
      begin
         case (state)
            m_idle :
               if (matr_start)
                  state <= m_read_a;
            m_read_a :
               state <= m_read_b;
            m_read_b :
               state <= m_accum;
            m_accum :
               if (k_idx == 2'(`MAT_N - 1))
               begin
                  k_idx <= '0;
                  state <= m_store;
               end
               else
               begin
                  k_idx <= k_idx + 1'b1;
                  state <= m_read_a;
               end
            m_store :
            begin
               state <= m_read_a;
               if (j_idx == 2'(`MAT_N - 1))
               begin
                  j_idx <= '0;
                  i_idx <= i_idx + 1'b1;
                  if (i_idx == 2'(`MAT_N - 1))
                  begin
                     i_idx <= '0;                          // ready for the next instruction
                     state <= m_done;
                  end
               end
               else
                  j_idx <= j_idx + 1'b1;
            end
            default :
            begin
               matr_count <= matr_count + 1'b1;            // one per instruction
               state      <= m_idle;
            end
         endcase
      end
   end

   // datapath
   always_ff @(posedge clk_50)
   begin
      if (state == m_read_b)
         a_val <= b_rdata;                                 // a term returns as b is addressed
      if (state == m_idle || state == m_store)
         acc <= '0;
      else if (state == m_accum)
         acc <= acc + $signed(a_val) * $signed(b_rdata);   // low 32 bits wrap
   end

   // the product region stays clear of both operands
   a_store : assert property (@(posedge clk_50) disable iff (!arst_n)
      b_we |-> ram_addr_t'(b_addr - base_a) >= `MAT_N * `MAT_N &&
               ram_addr_t'(b_addr - base_b) >= `MAT_N * `MAT_N)
      else $error("product store at word %0d overlaps an operand", b_addr);

endmodule

// ==== include/matr_params.svh ====
`ifndef MATR_PARAMS_SVH
`define MATR_PARAMS_SVH

`define INST_W      32            // one rv32 instruction
`define ADDR_W      32            // pc counts bytes
`define ROM_WORDS   64            // program space
`define RAM_WORDS   64
`define RAM_AW      6             // word index into data ram
`define MAT_N       3             // 3x3 operands
`define AXI_AW      12

`define REG_BASE_A  12'h100       // word index of matrix a
`define REG_BASE_B  12'h104       // word index of matrix b
`define REG_BASE_C  12'h108       // product lands here
`define REG_CTRL    12'h10C       // bit 0 run
`define REG_STATUS  12'h110       // busy, halted, count

`define MATR_OPCODE 7'b0001011    // custom-0 major opcode

`endif

// ==== testbench/matr_top_tb.sv ====
`timescale 1ns/1ps
`include "matr_params.svh"

module matr_top_tb;
   import matr_pkg::*;

   localparam int wait_limit = 200;                        // cycles per bus handshake
   localparam int run_limit  = 5000;                       // whole program incl. the product
   localparam int prog_words = 41;                         // pc 0 to 160
   localparam int n_steps    = 15;

   // one host bus access with its expected outcome
   typedef struct packed
   {
      logic [`AXI_AW-1:0] addr;
      logic [31:0]        data;
      logic               wr;                              // 1 write, 0 read
      logic [31:0]        exp;                             // expected read data
      logic [1:0]         resp;
   } step_t;

   logic               clk_50 = 1'b0;
   logic               arst_n;
   logic [`AXI_AW-1:0] awaddr;
   logic               awvalid;
   logic               awready;
   word_t              wdata;
   logic [3:0]         wstrb;
   logic               wvalid;
   logic               wready;
   logic [1:0]         bresp;
   logic               bvalid;
   logic               bready;
   logic [`AXI_AW-1:0] araddr;
   logic               arvalid;
   logic               arready;
   word_t              rdata;
   logic [1:0]         rresp;
   logic               rvalid;
   logic               rready;
   inst_t              inst;
   pc_t                inst_pc;
   logic               inst_valid;
   logic               inst_ready;
   logic               halted;

   logic [31:0] lcg_state = 32'd98;                        // seed
   step_t       steps [n_steps];
   inst_t       prog  [prog_words];                        // expected stream at pc 4 * index
   int          prog_idx = 0;                              // next expected word
   int          ma [9];                                    // row-major a
   int          mb [9];
   int          mc [9];                                    // reference product

   matr_top DUT (.*);

   always #50 clk_50 = ~clk_50;                            // 100 ns period

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Test FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("Test FAILED");
         $fatal(1, "mismatch");
      end
   endtask

   // aw and w presented together and the response taken right away
   task automatic axi_write(input logic [`AXI_AW-1:0] addr, input word_t data,
                            output logic [1:0] resp);
      int cnt;
      cnt = 0;
      @(posedge clk_50);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wvalid  <= 1'b1;
      @(negedge clk_50);
      while (!(awready && wready))                         // seen here and taken at next edge
      begin
         cnt++;
         if (cnt > wait_limit)
            abort_run("timeout waiting for awready and wready");
         @(negedge clk_50);
      end
      @(posedge clk_50);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b1;
      cnt = 0;
      @(negedge clk_50);
      while (!bvalid)
      begin
         cnt++;
         if (cnt > wait_limit)
            abort_run("timeout waiting for bvalid");
         @(negedge clk_50);
      end
      resp = bresp;
      @(posedge clk_50);                                   // b handshake
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [`AXI_AW-1:0] addr, output word_t data,
                           output logic [1:0] resp);
      int cnt;
      cnt = 0;
      @(posedge clk_50);
      araddr  <= addr;
      arvalid <= 1'b1;
      @(negedge clk_50);
      while (!arready)
      begin
         cnt++;
         if (cnt > wait_limit)
            abort_run("timeout waiting for arready");
         @(negedge clk_50);
      end
      @(posedge clk_50);
      arvalid <= 1'b0;
      rready  <= 1'b1;
      cnt = 0;
      @(negedge clk_50);
      while (!rvalid)                                      // one cycle for registers, two for ram
      begin
         cnt++;
         if (cnt > wait_limit)
            abort_run("timeout waiting for rvalid");
         @(negedge clk_50);
      end
      data = rdata;
      resp = rresp;
      @(posedge clk_50);
      rready <= 1'b0;
   endtask

   // random back-pressure with ready three times in four
   always @(posedge clk_50)
   begin : ready_gen
      logic [31:0] r;
      r = lcg_next();
      inst_ready <= r[31:30] != 2'b00;
   end

   // stream monitor sampling the falling edge before each handshake
   always @(negedge clk_50)
   begin
      if (arst_n && inst_valid && inst_ready)
      begin
         if (prog_idx >= prog_words)
            abort_run("instruction offered after the end of the program");
         else
         begin
            compare("inst_pc", inst_pc, pc_t'(4 * prog_idx));
            compare("inst", inst, prog[prog_idx]);
            prog_idx = prog_idx + 1;
         end
      end
   end

   initial
   begin : main
      logic [1:0] resp;
      word_t      rd;
      int         cnt;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = 4'hF;                                      // full words only
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      inst_ready = 1'b0;
      arst_n  = 1'b0;

      prog = '{32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013,
               32'h00000013, 32'hff810113, 32'h01412223, 32'h01312023,
               32'h00400993, 32'h00000a13, 32'h00000793, 32'h02400813,
               32'h04800893, 32'h00f8188b, 32'h00000513, 32'h02800613,
               32'h04800293, 32'h04c9d863, 32'h00000e33, 32'h41360e33,
               32'h000a0f13, 32'h03cf5863, 32'h0002a503, 32'h0042a583,
               32'h00428293, 32'h02a5d463, 32'h00050f93, 32'h00058513,
               32'h000f8593, 32'hfea2ae23, 32'h00b2a023, 32'h004f0f13,
               32'hfc000ae3, 32'h00498993, 32'hfa0008e3, 32'h004f0f13,
               32'hfc0002e3, 32'h00013983, 32'h00413a03, 32'h00810113,
               32'h00a54533};

      //          addr     data           wr    expected       resp
      steps[0]  = '{12'h110, 32'h0,        1'b0, 32'h0,        2'b00};   // status after reset
      steps[1]  = '{12'h0F0, 32'h5a5a1234, 1'b1, 32'h0,        2'b00};
      steps[2]  = '{12'h0FC, 32'hdeadbeef, 1'b1, 32'h0,        2'b00};   // last ram word
      steps[3]  = '{12'h0F0, 32'h0,        1'b0, 32'h5a5a1234, 2'b00};
      steps[4]  = '{12'h0FC, 32'h0,        1'b0, 32'hdeadbeef, 2'b00};
      steps[5]  = '{12'h200, 32'h0,        1'b0, 32'h0,        2'b10};   // unmapped read
      steps[6]  = '{12'h100, 32'd45,       1'b1, 32'h0,        2'b00};   // temporary base a
      steps[7]  = '{12'h100, 32'h0,        1'b0, 32'd45,       2'b00};
      steps[8]  = '{12'h100, 32'd0,        1'b1, 32'h0,        2'b00};
      steps[9]  = '{12'h104, 32'd9,        1'b1, 32'h0,        2'b00};
      steps[10] = '{12'h108, 32'd18,       1'b1, 32'h0,        2'b00};
      steps[11] = '{12'h100, 32'h0,        1'b0, 32'd0,        2'b00};
      steps[12] = '{12'h104, 32'h0,        1'b0, 32'd9,        2'b00};
      steps[13] = '{12'h108, 32'h0,        1'b0, 32'd18,       2'b00};
      steps[14] = '{12'h400, 32'h1,        1'b1, 32'h0,        2'b10};   // unmapped write

      // operands drawn at time 0 before the ready generator runs
      for (int n = 0; n < 9; n++)
      begin
         ma[n] = int'(lcg_next());
         mb[n] = int'(lcg_next());
      end
      for (int i = 0; i < 3; i++)
         for (int j = 0; j < 3; j++)
         begin
            mc[3*i+j] = 0;
            for (int k = 0; k < 3; k++)
               mc[3*i+j] = mc[3*i+j] + ma[3*i+k] * mb[3*k+j];   // int wraps at 32 bits
         end

      repeat (5) @(posedge clk_50);
      arst_n <= 1'b1;
      @(negedge clk_50);
      compare("inst_valid", inst_valid, 1'b0);
      compare("halted", halted, 1'b0);
      compare("bvalid", bvalid, 1'b0);
      compare("rvalid", rvalid, 1'b0);

      for (int s = 0; s < n_steps; s++)
      begin
         if (steps[s].wr)
         begin
            axi_write(steps[s].addr, steps[s].data, resp);
            compare($sformatf("bresp @%h", steps[s].addr), resp, steps[s].resp);
         end
         else
         begin
            axi_read(steps[s].addr, rd, resp);
            compare($sformatf("rdata @%h", steps[s].addr), rd, steps[s].exp);
            compare($sformatf("rresp @%h", steps[s].addr), resp, steps[s].resp);
         end
      end

      for (int n = 0; n < 9; n++)
      begin
         axi_write(12'(4 * n), word_t'(ma[n]), resp);      // a at word 0
         compare("bresp a", resp, 2'b00);
         axi_write(12'(36 + 4 * n), word_t'(mb[n]), resp); // b at word 9
         compare("bresp b", resp, 2'b00);
      end

      axi_write(`REG_CTRL, 32'h1, resp);                   // run
      compare("bresp ctrl", resp, 2'b00);

      cnt = 0;
      @(negedge clk_50);
      while (!halted)
      begin
         cnt++;
         if (cnt > run_limit)
            abort_run("timeout waiting for the fetch unit to halt");
         @(negedge clk_50);
      end
      compare("accepted instructions", prog_idx, prog_words);

      for (int n = 0; n < 9; n++)
      begin
         axi_read(12'(72 + 4 * n), rd, resp);              // c at word 18
         compare($sformatf("c[%0d]", n), rd, word_t'(mc[n]));
         compare("rresp c", resp, 2'b00);
      end
      axi_read(`REG_STATUS, rd, resp);
      compare("status", rd, 32'h00000102);                 // count 1 with halted set and idle
      compare("rresp status", resp, 2'b00);

      $display("Test OK");
      $finish;
   end

endmodule
